/* m26_frame_pkg.sv */
package m26_frame_pkg;

    localparam int M26_WORD_BITS = 16;

    // one sensor word, sent msb first
    typedef logic [M26_WORD_BITS-1:0] m26_word_t;

    // saturating status count
    typedef logic [7:0] m26_cnt_t;

    // frame markers
    localparam m26_word_t M26_HEADER  = 16'h5555;
    localparam m26_word_t M26_TRAILER = 16'haaaa;

    // largest legal data length in words
    localparam m26_word_t M26_MAX_LEN = 16'd570;

    // deframer states, one per field of the frame
    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_frame_cnt,
        st_length,
        st_data,
        st_trailer
    } ch_state_t;

endpackage

/* m26_out_pkg.sv */
package m26_out_pkg;

    localparam int FIFO_AW    = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // constant upper fields of every output word
    localparam logic [7:0] OUT_HEADER = 8'h20;
    localparam logic [3:0] OUT_IDENT  = 4'h1;

    // header, ident, two zero bits, then the stored entry
    typedef logic [31:0] out_word_t;

    // bit 17 lost, bit 16 frame start, 15:0 data
    typedef logic [17:0] fifo_entry_t;

    // one extra bit tells full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;

endpackage

/* m26_rx_ch.sv */
module m26_rx_ch (
    input  logic                    clk_rx,
    input  logic                    rst_sync,
    input  logic                    mkd,
    input  logic                    data_rx,
    output logic                    ch_write,
    output logic                    ch_frame_start,
    output m26_frame_pkg::m26_word_t ch_data,
    output logic                    ch_invalid
);
    import m26_frame_pkg::*;

    logic      mkd_prev;
    logic      mkd_rise;
    m26_word_t sreg;
    logic [3:0] bit_cnt;
    logic      word_vld;    // sreg holds a complete word
    logic [9:0] len_cnt;
    ch_state_t state;

    assign mkd_rise = mkd && !mkd_prev;

    // word assembly
    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            mkd_prev <= 1'b0;
            bit_cnt  <= 4'd0;
            word_vld <= 1'b0;
        end else begin
            mkd_prev <= mkd;
            if (mkd_rise) begin
                bit_cnt  <= 4'd1;   // this edge took bit 0 of the header
                word_vld <= 1'b0;
            end else begin
                bit_cnt  <= bit_cnt + 4'd1;
                word_vld <= (bit_cnt == 4'd15);
            end
        end
    end

    always_ff @(posedge clk_rx) begin
        sreg <= {sreg[M26_WORD_BITS-2:0], data_rx};
    end

    // frame structure
    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            state          <= st_idle;
            ch_write       <= 1'b0;
            ch_frame_start <= 1'b0;
            ch_invalid     <= 1'b0;
            len_cnt        <= 10'd0;
        end else begin
            ch_write       <= 1'b0;
            ch_frame_start <= 1'b0;
            ch_invalid     <= 1'b0;

            if (word_vld && state != st_idle) begin
                ch_write <= 1'b1;   // bad words are still written
                unique case (state)
                    st_header: begin
                        ch_frame_start <= 1'b1;
                        if (sreg != M26_HEADER) begin
                            ch_invalid <= 1'b1;
                            state      <= st_idle;
                        end else begin
                            state <= st_frame_cnt;
                        end
                    end
                    st_frame_cnt: state <= st_length;
                    st_length: begin
                        if (sreg > M26_MAX_LEN) begin
                            ch_invalid <= 1'b1;
                            state      <= st_idle;
                        end else begin
                            len_cnt <= sreg[9:0];
                            state   <= (sreg == '0) ? st_trailer : st_data;
                        end
                    end
                    st_data: begin
                        len_cnt <= len_cnt - 10'd1;
                        if (len_cnt == 10'd1)
                            state <= st_trailer;
                    end
                    st_trailer: begin
                        if (sreg != M26_TRAILER)
                            ch_invalid <= 1'b1;
                        state <= st_idle;   // wait for next marker
                    end
                    default: state <= st_idle;
                endcase
            end

            // marker restarts the frame whatever the state
            if (mkd_rise)
                state <= st_header;
        end
    end

    always_ff @(posedge clk_rx) begin
        ch_data <= sreg;
    end

endmodule

/* m26_word_merge.sv */
module m26_word_merge (
    input  logic                     clk_rx,
    input  logic                     rst_sync,
    input  logic                     enable,
    input  logic                     ts_header,
    input  logic [31:0]              timestamp,
    input  logic                     ch0_write,
    input  logic                     ch0_frame_start,
    input  m26_frame_pkg::m26_word_t ch0_data,
    input  logic                     ch0_invalid,
    input  logic                     ch1_write,
    input  logic                     ch1_frame_start,
    input  m26_frame_pkg::m26_word_t ch1_data,
    input  logic                     ch1_invalid,
    output logic                     fifo_wr,
    output m26_frame_pkg::m26_word_t fifo_din,
    output logic                     fifo_frame_start,
    output logic                     invalid_flag,
    output m26_frame_pkg::m26_cnt_t  invalid_count
);
    import m26_frame_pkg::*;

    logic        new_frame;
    logic        write_frame;
    logic        frame_en_now;
    logic        wr0;
    logic        wr1;
    logic [15:0] ts_buf;    // high half, goes out with the lane-1 header
    logic        hold_vld;
    m26_word_t   hold_data;
    logic        hold_fs;
    m26_word_t   ch1_src;
    logic        ch1_src_fs;
    logic        invalid_frame;
    logic        inv_any;
    logic        inv_rise;

    assign new_frame = ch0_write && ch0_frame_start;

    // lane-0 header decides for the whole frame, including itself
    assign frame_en_now = new_frame ? enable : write_frame;
    assign wr0          = ch0_write && frame_en_now;
    assign wr1          = ch1_write && frame_en_now;

    // lane 1 comes from the hold slot after a collision
    assign ch1_src    = hold_vld ? hold_data : ch1_data;
    assign ch1_src_fs = hold_vld ? hold_fs : ch1_frame_start;

    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            write_frame <= 1'b0;
            hold_vld    <= 1'b0;
            fifo_wr     <= 1'b0;
        end else begin
            if (new_frame)
                write_frame <= enable;
            hold_vld <= wr0 && wr1;
            fifo_wr  <= wr0 || wr1 || hold_vld;
        end
    end

    always_ff @(posedge clk_rx) begin
        if (new_frame)
            ts_buf <= timestamp[31:16];
        if (wr0 && wr1) begin
            hold_data <= ch1_data;
            hold_fs   <= ch1_frame_start;
        end
        fifo_frame_start <= wr0 && ch0_frame_start;  // lane 1 never marks a start
        if (wr0)
            fifo_din <= (ts_header && ch0_frame_start) ? timestamp[15:0] : ch0_data;
        else
            fifo_din <= (ts_header && ch1_src_fs) ? ts_buf : ch1_src;
    end

    // invalid frame tracking
    assign inv_any  = ch0_invalid || ch1_invalid;
    assign inv_rise = inv_any && (!invalid_frame || new_frame);

    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            invalid_frame <= 1'b0;
            invalid_flag  <= 1'b0;
            invalid_count <= '0;
        end else begin
            if (inv_any)
                invalid_frame <= 1'b1;
            else if (new_frame)
                invalid_frame <= 1'b0;
            invalid_flag <= inv_rise;
            if (inv_rise && frame_en_now && invalid_count != '1)
                invalid_count <= invalid_count + 8'd1;
        end
    end

endmodule

/* m26_out_fifo.sv */
module m26_out_fifo (
    input  logic                     clk_rx,
    input  logic                     rst_sync,
    input  logic                     fifo_wr,
    input  m26_frame_pkg::m26_word_t fifo_din,
    input  logic                     fifo_frame_start,
    input  logic                     fifo_read,
    output logic                     fifo_empty,
    output m26_out_pkg::out_word_t   fifo_data,
    output logic                     lost_error,
    output m26_frame_pkg::m26_cnt_t  lost_count
);
    import m26_out_pkg::*;

    fifo_entry_t mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    logic        full;
    logic        accept;
    logic        lost_now;
    logic        lost_flag;
    logic        entry_lost;

    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);

    assign accept   = fifo_wr && !full;
    assign lost_now = fifo_wr && full;     // word dropped this cycle

    // a kept frame start begins clean data
    assign entry_lost = lost_flag && !fifo_frame_start;

    always_ff @(posedge clk_rx) begin
        if (accept)
            mem[wr_ptr[FIFO_AW-1:0]] <= {entry_lost, fifo_frame_start, fifo_din};
    end

    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_read && !fifo_empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_rx) begin
        if (rst_sync) begin
            lost_flag  <= 1'b0;
            lost_count <= '0;
            lost_error <= 1'b0;
        end else begin
            if (lost_now)
                lost_flag <= 1'b1;
            else if (accept && fifo_frame_start)
                lost_flag <= 1'b0;
            if (lost_now && lost_count != '1)
                lost_count <= lost_count + 8'd1;   // saturates
            lost_error <= |lost_count;
        end
    end

    // head entry shows without a read
    assign fifo_data = {OUT_HEADER, OUT_IDENT, 2'b00, mem[rd_ptr[FIFO_AW-1:0]]};

endmodule

/* m26_rx_core.sv */
module m26_rx_core (
    input  logic                    CLK_RX,
    input  logic                    RST_SYNC,
    input  logic                    mkd,
    input  logic                    data0,
    input  logic                    data1,
    input  logic                    enable,
    input  logic                    ts_header,
    input  logic [31:0]             timestamp,
    input  logic                    fifo_read,
    output logic                    fifo_empty,
    output m26_out_pkg::out_word_t  fifo_data,
    output logic                    lost_error,
    output m26_frame_pkg::m26_cnt_t lost_count,
    output logic                    invalid_flag,
    output m26_frame_pkg::m26_cnt_t invalid_count
);
    import m26_frame_pkg::*;

    logic      ch0_write;
    logic      ch0_frame_start;
    m26_word_t ch0_data;
    logic      ch0_invalid;
    logic      ch1_write;
    logic      ch1_frame_start;
    m26_word_t ch1_data;
    logic      ch1_invalid;
    logic      fifo_wr;
    m26_word_t fifo_din;
    logic      fifo_frame_start;

    // both lanes share one marker
    m26_rx_ch ch0_i (
        .clk_rx         (CLK_RX),
        .rst_sync       (RST_SYNC),
        .mkd            (mkd),
        .data_rx        (data0),
        .ch_write       (ch0_write),
        .ch_frame_start (ch0_frame_start),
        .ch_data        (ch0_data),
        .ch_invalid     (ch0_invalid)
    );

    m26_rx_ch ch1_i (
        .clk_rx         (CLK_RX),
        .rst_sync       (RST_SYNC),
        .mkd            (mkd),
        .data_rx        (data1),
        .ch_write       (ch1_write),
        .ch_frame_start (ch1_frame_start),
        .ch_data        (ch1_data),
        .ch_invalid     (ch1_invalid)
    );

    m26_word_merge merge_i (
        .clk_rx           (CLK_RX),
        .rst_sync         (RST_SYNC),
        .enable           (enable),
        .ts_header        (ts_header),
        .timestamp        (timestamp),
        .ch0_write        (ch0_write),
        .ch0_frame_start  (ch0_frame_start),
        .ch0_data         (ch0_data),
        .ch0_invalid      (ch0_invalid),
        .ch1_write        (ch1_write),
        .ch1_frame_start  (ch1_frame_start),
        .ch1_data         (ch1_data),
        .ch1_invalid      (ch1_invalid),
        .fifo_wr          (fifo_wr),
        .fifo_din         (fifo_din),
        .fifo_frame_start (fifo_frame_start),
        .invalid_flag     (invalid_flag),
        .invalid_count    (invalid_count)
    );

    m26_out_fifo fifo_i (
        .clk_rx           (CLK_RX),
        .rst_sync         (RST_SYNC),
        .fifo_wr          (fifo_wr),
        .fifo_din         (fifo_din),
        .fifo_frame_start (fifo_frame_start),
        .fifo_read        (fifo_read),
        .fifo_empty       (fifo_empty),
        .fifo_data        (fifo_data),
        .lost_error       (lost_error),
        .lost_count       (lost_count)
    );

endmodule

/* m26_clk_gen.sv */
module m26_clk_gen (
    output logic CLK_RX,
    output logic RST_SYNC
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 10ns;   // 20 ns period

    initial begin
        CLK_RX = 1'b0;
        forever #(HALF_PERIOD) CLK_RX = ~CLK_RX;
    end

    initial begin
        RST_SYNC = 1'b1;
        repeat (2) @(negedge CLK_RX);   // covers two rising edges
        RST_SYNC = 1'b0;
    end

endmodule

/* tb_m26_tests.svh */
localparam logic [13:0] EXP_TOP      = {8'h20, 4'h1, 2'b00};
localparam int          FIFO_ENTRIES = 16;

function automatic m26_word_t lane_word(input int lane, input int idx);
    return (lane == 0) ? lane0_words[idx] : lane1_words[idx];
endfunction

// words a lane writes before it stops on an error or after the trailer
function automatic int written_count(input int lane);
    int n;
    int len;
    n   = lane0_words.size();
    len = int'(lane_word(lane, 2));
    if (lane_word(lane, 0) != M26_HEADER)
        return 1;
    if (len > int'(M26_MAX_LEN))
        return 3;
    return (len + 4 < n) ? len + 4 : n;
endfunction

task automatic make_frame(input int n_data, input m26_word_t len_word,
                          input m26_word_t trailer);
    logic [31:0] r;
    int          i;
    lane0_words.delete();
    lane1_words.delete();
    r = $urandom;
    lane0_words.push_back(M26_HEADER);
    lane1_words.push_back(M26_HEADER);
    lane0_words.push_back(r[15:0]);     // same frame count on both lanes
    lane1_words.push_back(r[15:0]);
    lane0_words.push_back(len_word);
    lane1_words.push_back(len_word);
    for (i = 0; i < n_data; i++) begin
        r = $urandom;
        lane0_words.push_back(r[15:0]);
        lane1_words.push_back(r[31:16]);
    end
    lane0_words.push_back(trailer);
    lane1_words.push_back(trailer);
endtask

// lane 0 then lane 1 per position, start flag on the lane-0 header only
task automatic build_expected(input logic use_ts, input logic [31:0] ts);
    int          n0;
    int          n1;
    int          i;
    logic [15:0] d;
    exp_words.delete();
    n0 = written_count(0);
    n1 = written_count(1);
    for (i = 0; i < n0 || i < n1; i++) begin
        if (i < n0) begin
            d = (use_ts && i == 0) ? ts[15:0] : lane0_words[i];
            exp_words.push_back({EXP_TOP, 1'b0, (i == 0), d});
        end
        if (i < n1) begin
            d = (use_ts && i == 0) ? ts[31:16] : lane1_words[i];
            exp_words.push_back({EXP_TOP, 2'b00, d});
        end
    end
endtask

task automatic check_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
        $display("[FAIL] %s: %s expected %0d actual %0d", test_name, what, exp, act);
        test_errors++;
    end
endtask

task automatic compare_words();
    int i;
    check_value("word count", exp_words.size(), got_words.size());
    for (i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
        assert (got_words[i] === exp_words[i]) else begin
            $display("[FAIL] %s: word %0d expected %08h actual %08h",
                     test_name, i, exp_words[i], got_words[i]);
            test_errors++;
        end
    end
endtask

task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
endtask

task automatic finish_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
        $display("%s: ok", test_name);
    end else begin
        tests_failed++;
        $display("%s: %0d errors", test_name, test_errors);
    end
endtask

task automatic basic_frame();
    start_test("basic_frame");
    check_value("fifo_empty after reset", 1, int'(fifo_empty));
    check_value("lost_count after reset", 0, int'(lost_count));
    check_value("invalid_count after reset", 0, int'(invalid_count));
    make_frame(3, 16'd3, M26_TRAILER);
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    compare_words();
    finish_test();
endtask

task automatic timestamp_header();
    start_test("timestamp_header");
    ts_header = 1'b1;
    timestamp = $urandom;   // steady for the whole frame
    make_frame(3, 16'd3, M26_TRAILER);
    send_frame();
    read_all();
    build_expected(1'b1, timestamp);
    compare_words();
    ts_header = 1'b0;
    finish_test();
endtask

task automatic enable_gating();
    start_test("enable_gating");
    enable = 1'b0;
    make_frame(3, 16'd3, M26_TRAILER);
    send_frame();
    check_value("fifo_empty with enable low", 1, int'(fifo_empty));
    read_all();
    check_value("words with enable low", 0, got_words.size());
    enable = 1'b1;
    make_frame(4, 16'd4, M26_TRAILER);
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    compare_words();
    finish_test();
endtask

task automatic invalid_frames();
    int pulses0;
    int count0;
    start_test("invalid_frames");
    pulses0 = inv_pulses;
    count0  = int'(invalid_count);
    make_frame(2, 16'd2, 16'h1234);
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    compare_words();
    check_value("invalid_flag pulses after bad trailer", pulses0 + 1, inv_pulses);
    make_frame(2, 16'd600, M26_TRAILER);   // longer than legal
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    compare_words();
    check_value("invalid_flag pulses after bad length", pulses0 + 2, inv_pulses);
    check_value("invalid_count", count0 + 2, int'(invalid_count));
    finish_test();
endtask

task automatic overflow_recovery();
    start_test("overflow_recovery");
    make_frame(12, 16'd12, M26_TRAILER);
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    check_value("lost_count", exp_words.size() - FIFO_ENTRIES, int'(lost_count));
    check_value("lost_error", 1, int'(lost_error));
    while (exp_words.size() > FIFO_ENTRIES)
        void'(exp_words.pop_back());
    compare_words();
    make_frame(3, 16'd3, M26_TRAILER);     // lost flag must be clear again
    send_frame();
    read_all();
    build_expected(1'b0, 32'h0);
    compare_words();
    finish_test();
endtask

/* tb_m26_rx.sv */
module tb_m26_rx;
    timeunit 1ns;
    timeprecision 1ps;

    import m26_frame_pkg::*;

    localparam logic [31:0] SEED         = 32'h549743bb;
    localparam int          READ_TIMEOUT = 200;

    logic        CLK_RX;
    logic        RST_SYNC;
    logic        mkd;
    logic        data0;
    logic        data1;
    logic        enable;
    logic        ts_header;
    logic [31:0] timestamp;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        lost_error;
    logic [7:0]  lost_count;
    logic        invalid_flag;
    logic [7:0]  invalid_count;

    m26_word_t   lane0_words[$];
    m26_word_t   lane1_words[$];
    logic [31:0] exp_words[$];
    logic [31:0] got_words[$];
    string       test_name;
    int          test_errors;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          inv_pulses;
    int          waited;

    m26_clk_gen clk_gen_i (
        .CLK_RX   (CLK_RX),
        .RST_SYNC (RST_SYNC)
    );

    m26_rx_core dut_i (
        .CLK_RX        (CLK_RX),
        .RST_SYNC      (RST_SYNC),
        .mkd           (mkd),
        .data0         (data0),
        .data1         (data1),
        .enable        (enable),
        .ts_header     (ts_header),
        .timestamp     (timestamp),
        .fifo_read     (fifo_read),
        .fifo_empty    (fifo_empty),
        .fifo_data     (fifo_data),
        .lost_error    (lost_error),
        .lost_count    (lost_count),
        .invalid_flag  (invalid_flag),
        .invalid_count (invalid_count)
    );

    always @(negedge CLK_RX) begin
        if (invalid_flag === 1'b1)
            inv_pulses <= inv_pulses + 1;   // flag is one cycle wide
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $finish;
    endtask

    // both lanes in parallel, msb first, marker on the first 4 header bits
    task automatic send_frame();
        int i;
        int b;
        for (i = 0; i < lane0_words.size(); i++) begin
            for (b = 15; b >= 0; b--) begin
                @(negedge CLK_RX);
                mkd   = (i == 0) && (b >= 12);
                data0 = lane0_words[i][b];
                data1 = lane1_words[i][b];
            end
        end
        repeat (12) begin
            @(negedge CLK_RX);
            mkd   = 1'b0;
            data0 = 1'b0;
            data1 = 1'b0;
        end
    endtask

    // pop until the FIFO has stayed empty for a while
    task automatic read_all();
        int idle;
        int cycles;
        got_words.delete();
        idle   = 0;
        cycles = 0;
        while (idle < 10) begin
            @(negedge CLK_RX);
            fifo_read = !fifo_empty;
            if (!fifo_empty) begin
                got_words.push_back(fifo_data);
                idle = 0;
            end else begin
                idle++;
            end
            cycles++;
            if (cycles > READ_TIMEOUT)
                abort_on_timeout("FIFO did not run empty while reading");
        end
        fifo_read = 1'b0;
    endtask

    `include "tb_m26_tests.svh"

    initial begin
        void'($urandom(SEED));
        mkd          = 1'b0;
        data0        = 1'b0;
        data1        = 1'b0;
        enable       = 1'b1;
        ts_header    = 1'b0;
        timestamp    = 32'h0;
        fifo_read    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        waited       = 0;
        @(negedge CLK_RX);
        while (RST_SYNC !== 1'b0) begin
            @(negedge CLK_RX);
            waited++;
            if (waited > 20)
                abort_on_timeout("reset was never released");
        end

        basic_frame();
        timestamp_header();
        enable_gating();
        invalid_frames();
        overflow_recovery();

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* m26_rx.f */
+incdir+.
m26_frame_pkg.sv
m26_out_pkg.sv
m26_rx_ch.sv
m26_word_merge.sv
m26_out_fifo.sv
m26_rx_core.sv
m26_clk_gen.sv
tb_m26_rx.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f m26_rx.f --top-module tb_m26_rx -Mdir obj_dir -o sim_m26_rx
	./obj_dir/sim_m26_rx | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
